// File: run.sh
#!/usr/bin/env bash
# build the sd spi init testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module sd_spi_init_tb -f sim.f -o sd_spi_init_sim \
  && ./obj_dir/sd_spi_init_sim \
  || { echo "simulation failed"; exit 1; }

// File: sim.f
src/sd_spi_pkg.sv
src/sd_cmd_if.sv
src/sd_clk_gen.sv
src/sd_cmd_engine.sv
src/sd_init_fsm.sv
src/sd_spi_init.sv
tests/tb_clock.sv
tests/sd_card_model.sv
tests/sd_cmd_engine_sva.sv
tests/sd_spi_init_tb.sv

// File: src/sd_clk_gen.sv
`timescale 1ns/1ns

module sd_clk_gen
  import sd_spi_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic fast_mode,
  output logic sd_cclk,
  output logic fall_tick,
  output logic rise_tick
);

  half_period_t div_q;
  half_period_t reload;

  // rate picked at each toggle, so a mode change waits for the next edge
  assign reload = fast_mode ? half_period_t'(FAST_HALF_PERIOD - 1)
                            : half_period_t'(SLOW_HALF_PERIOD - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // first edge one full slow half period after reset
      div_q     <= half_period_t'(SLOW_HALF_PERIOD - 1);
      sd_cclk   <= 1'b0;
      fall_tick <= 1'b0;
      rise_tick <= 1'b0;
    end else if (div_q == '0) begin
      div_q     <= reload;
      sd_cclk   <= ~sd_cclk;
      // strobes line up with the new sd_cclk level
      rise_tick <= ~sd_cclk;
      fall_tick <= sd_cclk;
    end else begin
      div_q     <= div_q - 1'b1;
      rise_tick <= 1'b0;
      fall_tick <= 1'b0;
    end
  end

endmodule

// File: src/sd_cmd_engine.sv
`timescale 1ns/1ns

module sd_cmd_engine
  import sd_spi_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     fall_tick,
  input  logic     rise_tick,
  input  logic     sd_data0,
  output logic     sd_cmd,
  sd_cmd_if.engine bus
);

  engine_state_t state_q;
  // frame position while sending, samples or bits while receiving
  bit_cnt_t      bit_cnt_q;
  logic          timeout_q;

  // payload
  logic [CMD_HEAD_BITS-1:0] head_q;
  crc7_t                    crc_q;
  resp_t                    resp_q;

  crc7_t      crc_next;
  logic       shift_head;
  logic       shift_crc;
  logic       start_seen;
  logic       capture;
  logic       tmo_hit;
  logic [5:0] rx_idx;
  bit_cnt_t   resp_last;

  // serial crc7 step on the outgoing head bit
  assign crc_next = {crc_q[5:0], 1'b0}
                  ^ ({7{head_q[CMD_HEAD_BITS-1] ^ crc_q[6]}} & CRC7_POLY);

  assign shift_head = (state_q == SEND) && fall_tick
                   && (bit_cnt_q < bit_cnt_t'(CMD_HEAD_BITS));
  assign shift_crc  = (state_q == SEND) && fall_tick
                   && (bit_cnt_q >= bit_cnt_t'(CMD_HEAD_BITS))
                   && (bit_cnt_q < bit_cnt_t'(CMD_FRAME_BITS - 1));

  // a low sample while hunting is the response start bit
  assign start_seen = (state_q == WAIT_START) && rise_tick && !sd_data0;
  assign capture    = start_seen || ((state_q == RECEIVE) && rise_tick);
  assign tmo_hit    = (state_q == WAIT_START) && rise_tick && sd_data0
                   && (bit_cnt_q == bit_cnt_t'(RESP_TIMEOUT_BITS - 1));

  // start bit lands in the msb, later bits fill downwards
  assign rx_idx = (state_q == WAIT_START) ? 6'(R7_BITS - 1)
                                          : 6'(R7_BITS - 1) - bit_cnt_q[5:0];

  assign resp_last = bus.long_resp ? bit_cnt_t'(R7_BITS - 1) : bit_cnt_t'(R1_BITS - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      timeout_q <= 1'b0;
      sd_cmd    <= 1'b1;
    end else begin
      case (state_q)
        IDLE: begin
          if (bus.start) begin
            bit_cnt_q <= '0;
            timeout_q <= 1'b0;
            state_q   <= SEND;
          end
        end
        SEND: begin
          // one frame bit per sd clock, msb first
          if (fall_tick) begin
            if (shift_head) begin
              sd_cmd <= head_q[CMD_HEAD_BITS-1];
            end else if (shift_crc) begin
              sd_cmd <= crc_q[6];
            end else begin
              // end bit, line then idles high
              sd_cmd <= 1'b1;
            end
            if (bit_cnt_q == bit_cnt_t'(CMD_FRAME_BITS - 1)) begin
              bit_cnt_q <= '0;
              state_q   <= WAIT_START;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        WAIT_START: begin
          if (start_seen) begin
            bit_cnt_q <= bit_cnt_t'(1);
            state_q   <= RECEIVE;
          end else if (tmo_hit) begin
            timeout_q <= 1'b1;
            state_q   <= FINISH;
          end else if (rise_tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end
        RECEIVE: begin
          if (rise_tick) begin
            if (bit_cnt_q == resp_last) begin
              state_q <= FINISH;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        default: begin
          // finish lasts one cycle
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bus.start && (state_q == IDLE)) begin
      // start 0, transmit 1, index, argument
      head_q <= {2'b01, bus.cmd_index, bus.cmd_arg};
      crc_q  <= '0;
      // unreceived bits stay ones, so a timeout reads all ones
      resp_q <= '1;
    end else begin
      if (shift_head) begin
        head_q <= {head_q[CMD_HEAD_BITS-2:0], 1'b0};
        crc_q  <= crc_next;
      end else if (shift_crc) begin
        crc_q  <= {crc_q[5:0], 1'b0};
      end
      if (capture) begin
        resp_q[rx_idx] <= sd_data0;
      end
    end
  end

  assign bus.ready   = (state_q == IDLE);
  assign bus.done    = (state_q == FINISH);
  assign bus.resp    = resp_q;
  assign bus.timeout = timeout_q;

endmodule

// File: src/sd_cmd_if.sv
`timescale 1ns/1ns

interface sd_cmd_if
  import sd_spi_pkg::*;
();

  // request side, held stable from start to done
  logic       start;
  cmd_index_t cmd_index;
  cmd_arg_t   cmd_arg;
  // 40-bit response when set, r1 only otherwise
  logic       long_resp;

  // completion side, resp and timeout valid with done
  logic       ready;
  logic       done;
  resp_t      resp;
  logic       timeout;

  modport host (
    output start, cmd_index, cmd_arg, long_resp,
    input  ready, done, resp, timeout
  );

  modport engine (
    input  start, cmd_index, cmd_arg, long_resp,
    output ready, done, resp, timeout
  );

endinterface

// File: src/sd_init_fsm.sv
`timescale 1ns/1ns

module sd_init_fsm
  import sd_spi_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   rise_tick,
  output logic   fast_mode,
  output logic   sd_cs,
  output logic   init_done,
  output logic   init_error,
  output logic   card_hc,
  sd_cmd_if.host bus
);

  init_state_t state_q;
  pwr_cnt_t    pwr_cnt_q;
  // shared by the cmd0 and acmd41 loops
  retry_cnt_t  retry_q;
  logic        pending_q;
  logic        card_v2_q;

  // latched completion
  resp_t                resp_q;
  logic                 tmo_q;
  logic [R1_BITS-1:0]   r1;
  logic                 is_send;

  assign r1 = resp_q[R7_BITS-1 -: R1_BITS];

  // command fields follow the state, stable while a send state waits
  always_comb begin
    is_send       = 1'b1;
    bus.cmd_index = CMD_GO_IDLE;
    bus.cmd_arg   = '0;
    bus.long_resp = 1'b0;
    case (state_q)
      CMD0_SEND: begin
        bus.cmd_index = CMD_GO_IDLE;
      end
      CMD8_SEND: begin
        bus.cmd_index = CMD_SEND_IF_COND;
        bus.cmd_arg   = ARG_IF_COND;
        bus.long_resp = 1'b1;
      end
      CMD58A_SEND, CMD58B_SEND: begin
        bus.cmd_index = CMD_READ_OCR;
        bus.long_resp = 1'b1;
      end
      CMD55_SEND: begin
        bus.cmd_index = CMD_APP_CMD;
      end
      ACMD41_SEND: begin
        // hcs only offered to version 2 cards
        bus.cmd_index = ACMD_SD_SEND_OP_COND;
        bus.cmd_arg   = card_v2_q ? ARG_HCS : '0;
      end
      CMD16_SEND: begin
        bus.cmd_index = CMD_SET_BLOCKLEN;
        bus.cmd_arg   = ARG_BLOCK_LEN;
      end
      default: begin
        is_send = 1'b0;
      end
    endcase
  end

  // single cycle request once per send state
  assign bus.start = is_send && !pending_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= POWERUP;
      pwr_cnt_q <= '0;
      retry_q   <= '0;
      pending_q <= 1'b0;
      card_v2_q <= 1'b0;
      card_hc   <= 1'b0;
      fast_mode <= 1'b0;
      sd_cs     <= 1'b1;
    end else begin
      if (bus.start) begin
        pending_q <= 1'b1;
      end
      if (bus.done) begin
        pending_q <= 1'b0;
      end
      case (state_q)
        POWERUP: begin
          // cs high for the power-up clocks, then low for good
          if (rise_tick) begin
            if (pwr_cnt_q == pwr_cnt_t'(POWERUP_SD_CLOCKS - 1)) begin
              sd_cs   <= 1'b0;
              state_q <= CMD0_SEND;
            end else begin
              pwr_cnt_q <= pwr_cnt_q + 1'b1;
            end
          end
        end
        CMD0_CHECK: begin
          if (!tmo_q && (r1 == R1_IDLE)) begin
            retry_q <= '0;
            state_q <= CMD8_SEND;
          end else if (retry_q == retry_cnt_t'(RETRY_LIMIT - 1)) begin
            state_q <= FAILED;
          end else begin
            retry_q <= retry_q + 1'b1;
            state_q <= CMD0_SEND;
          end
        end
        CMD8_CHECK: begin
          // illegal command means a version 1 card
          if (tmo_q) begin
            state_q <= FAILED;
          end else if (r1 == R1_ILLEGAL_IDLE) begin
            card_v2_q <= 1'b0;
            state_q   <= CMD58A_SEND;
          end else if ((r1 == R1_IDLE) && (resp_q[11:0] == ARG_IF_COND[11:0])) begin
            card_v2_q <= 1'b1;
            state_q   <= CMD58A_SEND;
          end else begin
            state_q <= FAILED;
          end
        end
        CMD58A_CHECK: begin
          state_q <= tmo_q ? FAILED : CMD55_SEND;
        end
        CMD55_CHECK: begin
          state_q <= tmo_q ? FAILED : ACMD41_SEND;
        end
        ACMD41_CHECK: begin
          if (tmo_q) begin
            state_q <= FAILED;
          end else if (r1 == R1_READY) begin
            state_q <= CMD58B_SEND;
          end else if ((r1 == R1_IDLE) && (retry_q != retry_cnt_t'(RETRY_LIMIT - 1))) begin
            // still busy, poll again
            retry_q <= retry_q + 1'b1;
            state_q <= CMD55_SEND;
          end else begin
            state_q <= FAILED;
          end
        end
        CMD58B_CHECK: begin
          // ocr bit 30 is ccs, only meaningful for version 2
          if (tmo_q) begin
            state_q <= FAILED;
          end else begin
            card_hc   <= card_v2_q & resp_q[30];
            fast_mode <= 1'b1;
            state_q   <= CMD16_SEND;
          end
        end
        CMD16_CHECK: begin
          state_q <= (!tmo_q && (r1 == R1_READY)) ? DONE : FAILED;
        end
        DONE, FAILED: begin
          state_q <= state_q;
        end
        default: begin
          // send states move to their check state on done
          if (bus.done) begin
            state_q <= init_state_t'(state_q + 5'd1);
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bus.done) begin
      resp_q <= bus.resp;
      tmo_q  <= bus.timeout;
    end
  end

  assign init_done  = (state_q == DONE);
  assign init_error = (state_q == FAILED);

endmodule

// File: src/sd_spi_init.sv
`timescale 1ns/1ns

module sd_spi_init (
  input  logic clk,
  input  logic rst_n,
  input  logic sd_data0,
  output logic sd_cclk,
  output logic sd_cmd,
  output logic sd_cs,
  output logic init_done,
  output logic init_error,
  output logic card_hc
);

  // sd clock edge strobes in the clk domain
  logic fall_tick;
  logic rise_tick;
  logic fast_mode;

  // sequencer to engine command channel
  sd_cmd_if cmd_bus ();

  sd_clk_gen u_clk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .fast_mode (fast_mode),
    .sd_cclk   (sd_cclk),
    .fall_tick (fall_tick),
    .rise_tick (rise_tick)
  );

  sd_cmd_engine u_cmd_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .fall_tick (fall_tick),
    .rise_tick (rise_tick),
    .sd_data0  (sd_data0),
    .sd_cmd    (sd_cmd),
    .bus       (cmd_bus.engine)
  );

  sd_init_fsm u_init_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .rise_tick  (rise_tick),
    .fast_mode  (fast_mode),
    .sd_cs      (sd_cs),
    .init_done  (init_done),
    .init_error (init_error),
    .card_hc    (card_hc),
    .bus        (cmd_bus.host)
  );

endmodule

// File: src/sd_spi_pkg.sv
package sd_spi_pkg;

  // sd clock divider, in clk cycles per half period
  // slow rate kept small so simulation stays short
  localparam int SLOW_HALF_PERIOD  = 8;
  localparam int FAST_HALF_PERIOD  = 2;

  // init timing and limits
  localparam int POWERUP_SD_CLOCKS = 80;
  localparam int RETRY_LIMIT       = 10;
  localparam int RESP_TIMEOUT_BITS = 100;

  // frame and response sizes in bits
  localparam int CMD_FRAME_BITS    = 48;
  localparam int CMD_HEAD_BITS     = 40;
  localparam int R1_BITS           = 8;
  localparam int R7_BITS           = 40;

  typedef logic [5:0]                             cmd_index_t;
  typedef logic [31:0]                            cmd_arg_t;
  typedef logic [6:0]                             crc7_t;
  typedef logic [R7_BITS-1:0]                     resp_t;
  typedef logic [3:0]                             retry_cnt_t;
  typedef logic [7:0]                             half_period_t;
  // wide enough for frame position and timeout samples
  typedef logic [$clog2(RESP_TIMEOUT_BITS)-1:0]   bit_cnt_t;
  typedef logic [$clog2(POWERUP_SD_CLOCKS)-1:0]   pwr_cnt_t;

  // x^7 + x^3 + 1 without the top term
  localparam crc7_t CRC7_POLY = 7'h09;

  localparam cmd_index_t CMD_GO_IDLE          = 6'd0;
  localparam cmd_index_t CMD_SEND_IF_COND     = 6'd8;
  localparam cmd_index_t CMD_SET_BLOCKLEN     = 6'd16;
  localparam cmd_index_t ACMD_SD_SEND_OP_COND = 6'd41;
  localparam cmd_index_t CMD_APP_CMD          = 6'd55;
  localparam cmd_index_t CMD_READ_OCR         = 6'd58;

  // voltage range 1, check pattern aa
  localparam cmd_arg_t ARG_IF_COND   = 32'h0000_01AA;
  localparam cmd_arg_t ARG_HCS       = 32'h4000_0000;
  localparam cmd_arg_t ARG_BLOCK_LEN = 32'd512;

  localparam logic [R1_BITS-1:0] R1_READY        = 8'h00;
  localparam logic [R1_BITS-1:0] R1_IDLE         = 8'h01;
  localparam logic [R1_BITS-1:0] R1_ILLEGAL_IDLE = 8'h05;

  typedef enum logic [2:0] {IDLE, SEND, WAIT_START, RECEIVE, FINISH} engine_state_t;

  // each check state directly follows its send state
  typedef enum logic [4:0] {
    POWERUP,
    CMD0_SEND, CMD0_CHECK,
    CMD8_SEND, CMD8_CHECK,
    CMD58A_SEND, CMD58A_CHECK,
    CMD55_SEND, CMD55_CHECK,
    ACMD41_SEND, ACMD41_CHECK,
    CMD58B_SEND, CMD58B_CHECK,
    CMD16_SEND, CMD16_CHECK,
    DONE, FAILED
  } init_state_t;

endpackage

// File: tests/sd_card_model.sv
`timescale 1ns/1ns

module sd_card_model
  import sd_spi_pkg::*;
(
  input  logic rst_n,
  input  logic sd_cclk,
  input  logic sd_cs,
  input  logic sd_cmd,
  output logic sd_data0,
  // card personality
  input  logic v2,
  input  logic hc,
  input  int   acmd41_busy_count,
  input  logic silent
);

  // log of received frames and the sd clock half period at their last bit
  logic [47:0] frame_log [0:63];
  int          half_log  [0:63];
  int          frame_cnt;
  // rising sd clocks seen with cs high
  int          pwr_clocks;

  logic [47:0] rx_sr;
  int          rx_cnt;
  // reply bits, msb goes out first, idle ones behind
  logic [63:0] tx_sr;
  logic        next_bit;
  int          busy_left;
  logic        ready;
  time         fall_time;
  logic [7:0]  r1;
  logic [39:0] resp;

  // serial lfsr form of crc7
  function automatic logic [6:0] crc_of_head(input logic [39:0] head);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = head[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  // card samples cmd on the rising sd clock
  always @(posedge sd_cclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt  = 0;
      pwr_clocks = 0;
      rx_cnt     = 0;
      rx_sr      = '0;
      tx_sr      = '1;
      next_bit   = 1'b1;
      busy_left  = acmd41_busy_count;
      ready      = 1'b0;
    end else if (sd_cs) begin
      pwr_clocks = pwr_clocks + 1;
    end else begin
      // a low bit on an idle line opens a frame
      if ((rx_cnt > 0) || !sd_cmd) begin
        rx_sr  = {rx_sr[46:0], sd_cmd};
        rx_cnt = rx_cnt + 1;
      end
      if (rx_cnt == 48) begin
        rx_cnt = 0;
        if (frame_cnt < 64) begin
          frame_log[frame_cnt] = rx_sr;
          half_log[frame_cnt]  = int'($time - fall_time);
        end
        frame_cnt = frame_cnt + 1;
        r1   = ready ? R1_READY : R1_IDLE;
        resp = {r1, 32'hFFFF_FFFF};
        case (rx_sr[45:40])
          CMD_GO_IDLE: begin
            resp = {R1_IDLE, 32'hFFFF_FFFF};
          end
          CMD_SEND_IF_COND: begin
            // v2 echoes voltage and pattern, v1 rejects the command
            if (v2) begin
              resp = {R1_IDLE, 20'h0, rx_sr[19:8]};
            end else begin
              resp = {R1_ILLEGAL_IDLE, 32'hFFFF_FFFF};
            end
          end
          CMD_READ_OCR: begin
            // busy bit 31 set once ready, ccs in bit 30
            resp = {r1, ready, hc, 6'b0, 24'hFF8000};
          end
          ACMD_SD_SEND_OP_COND: begin
            if (busy_left > 0) begin
              busy_left = busy_left - 1;
              resp      = {R1_IDLE, 32'hFFFF_FFFF};
            end else begin
              ready = 1'b1;
              resp  = {R1_READY, 32'hFFFF_FFFF};
            end
          end
          CMD_APP_CMD, CMD_SET_BLOCKLEN: begin
            resp = {r1, 32'hFFFF_FFFF};
          end
          default: begin
            resp = {R1_ILLEGAL_IDLE, 32'hFFFF_FFFF};
          end
        endcase
        // flag a com crc error in r1
        if (crc_of_head(rx_sr[47:8]) != rx_sr[7:1]) begin
          resp[39:32] = resp[39:32] | 8'h08;
        end
        // two idle bits, then the reply
        if (!silent) begin
          tx_sr = {2'b11, resp, 22'h3F_FFFF};
        end
      end
      next_bit = tx_sr[63];
      tx_sr    = {tx_sr[62:0], 1'b1};
    end
  end

  // data0 moves just after the falling sd clock
  initial begin
    sd_data0 = 1'b1;
    forever begin
      @(negedge sd_cclk);
      fall_time = $time;
      #1;
      sd_data0 = next_bit;
    end
  end

endmodule

// File: tests/sd_cmd_engine_sva.sv
`timescale 1ns/1ns

module sd_cmd_engine_sva (
  input logic clk,
  input logic rst_n,
  input logic fall_tick,
  input logic sd_cmd,
  input logic start,
  input logic ready,
  input logic done,
  input logic timeout
);

  // done is a one cycle strobe
  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done held for more than one cycle");

  start_while_ready: assert property (@(posedge clk) disable iff (!rst_n) start |-> ready)
    else $error("start seen while the engine was busy");

  // cmd line only moves in the cycle after a fall strobe
  cmd_on_fall: assert property (@(posedge clk) disable iff (!rst_n)
    (sd_cmd != $past(sd_cmd)) |-> $past(fall_tick))
    else $error("sd_cmd changed outside a fall_tick cycle");

  timeout_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    (timeout && !$past(timeout)) |-> done)
    else $error("timeout raised without done");

endmodule

bind sd_cmd_engine sd_cmd_engine_sva u_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .fall_tick (fall_tick),
  .sd_cmd    (sd_cmd),
  .start     (bus.start),
  .ready     (bus.ready),
  .done      (bus.done),
  .timeout   (bus.timeout)
);

// File: tests/sd_spi_init_tb.sv
`timescale 1ns/1ns

module sd_spi_init_tb
  import sd_spi_pkg::*;
();

  localparam int CLK_PERIOD_NS = 4;
  localparam int SCENARIOS     = 4;

  logic clk;
  logic rst_n;
  logic restart;
  logic sd_data0;
  logic sd_cclk;
  logic sd_cmd;
  logic sd_cs;
  logic init_done;
  logic init_error;
  logic card_hc;

  // card personality for the running scenario
  logic cfg_v2;
  logic cfg_hc;
  logic cfg_silent;
  int   cfg_busy;
  int   rand_busy;
  int   seed;

  // expected result, {index, argument} per frame
  logic [37:0] exp_cmds [$];
  logic        exp_done;
  logic        exp_hc;

  int     ended_cnt;
  int     checked_cnt;
  longint budget_ns;

  tb_clock clock_gen (
    .restart (restart),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  sd_card_model card (
    .rst_n             (rst_n),
    .sd_cclk           (sd_cclk),
    .sd_cs             (sd_cs),
    .sd_cmd            (sd_cmd),
    .sd_data0          (sd_data0),
    .v2                (cfg_v2),
    .hc                (cfg_hc),
    .acmd41_busy_count (cfg_busy),
    .silent            (cfg_silent)
  );

  sd_spi_init UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .sd_data0   (sd_data0),
    .sd_cclk    (sd_cclk),
    .sd_cmd     (sd_cmd),
    .sd_cs      (sd_cs),
    .init_done  (init_done),
    .init_error (init_error),
    .card_hc    (card_hc)
  );

  // long division of the head by x^7 + x^3 + 1
  function automatic logic [6:0] crc7_ref(input logic [39:0] head);
    logic [46:0] rem;
    rem = {head, 7'b0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) begin
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
    end
    return rem[6:0];
  endfunction

  // outcome and command list of the init sequence for one card
  function automatic void expected_outcome(input logic v2, input logic hc, input int busy,
                                           input logic silent);
    int polls;
    exp_cmds.delete();
    exp_hc   = 1'b0;
    exp_done = 1'b0;
    polls    = (busy < RETRY_LIMIT) ? busy + 1 : RETRY_LIMIT;
    if (silent) begin
      // every cmd0 times out
      for (int i = 0; i < RETRY_LIMIT; i++) begin
        exp_cmds.push_back({CMD_GO_IDLE, 32'h0});
      end
    end else begin
      exp_cmds.push_back({CMD_GO_IDLE, 32'h0});
      exp_cmds.push_back({CMD_SEND_IF_COND, ARG_IF_COND});
      exp_cmds.push_back({CMD_READ_OCR, 32'h0});
      for (int i = 0; i < polls; i++) begin
        exp_cmds.push_back({CMD_APP_CMD, 32'h0});
        exp_cmds.push_back({ACMD_SD_SEND_OP_COND, v2 ? ARG_HCS : 32'h0});
      end
      // card ready within the allowed polls
      if (busy < RETRY_LIMIT) begin
        exp_cmds.push_back({CMD_READ_OCR, 32'h0});
        exp_cmds.push_back({CMD_SET_BLOCKLEN, ARG_BLOCK_LEN});
        exp_done = 1'b1;
        exp_hc   = v2 & hc;
      end
    end
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("** FAIL **");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic load_config(input int n);
    case (n)
      // v2 high capacity, random busy polls
      0: begin
        cfg_v2     = 1'b1;
        cfg_hc     = 1'b1;
        cfg_busy   = rand_busy;
        cfg_silent = 1'b0;
      end
      // v1 card reporting ccs, which must be ignored
      1: begin
        cfg_v2     = 1'b0;
        cfg_hc     = 1'b1;
        cfg_busy   = 2;
        cfg_silent = 1'b0;
      end
      // never leaves idle in acmd41
      2: begin
        cfg_v2     = 1'b1;
        cfg_hc     = 1'b0;
        cfg_busy   = 1000;
        cfg_silent = 1'b0;
      end
      default: begin
        cfg_v2     = 1'b1;
        cfg_hc     = 1'b1;
        cfg_busy   = 0;
        cfg_silent = 1'b1;
      end
    endcase
  endtask

  task automatic compare_results();
    logic [47:0] frame;
    int          want_half;
    check_value("init_done", 64'(init_done), 64'(exp_done));
    check_value("init_error", 64'(init_error), 64'(!exp_done));
    check_value("card_hc", 64'(card_hc), 64'(exp_hc));
    check_value("frame count", 64'(card.frame_cnt), 64'(exp_cmds.size()));
    check_value("powerup clocks >= POWERUP_SD_CLOCKS",
                64'(card.pwr_clocks >= POWERUP_SD_CLOCKS), 64'(1));
    for (int i = 0; i < card.frame_cnt; i++) begin
      frame = card.frame_log[i];
      check_value("cmd index and arg", 64'(frame[45:8]), 64'(exp_cmds[i]));
      check_value("start bit", 64'(frame[47]), 64'(0));
      check_value("transmit bit", 64'(frame[46]), 64'(1));
      check_value("end bit", 64'(frame[0]), 64'(1));
      check_value("crc7", 64'(frame[7:1]), 64'(crc7_ref(frame[47:8])));
      // only cmd16 runs after the switch to the fast clock
      want_half = (frame[45:40] == CMD_SET_BLOCKLEN) ? FAST_HALF_PERIOD : SLOW_HALF_PERIOD;
      check_value("sd_cclk half period ns", 64'(card.half_log[i]),
                  64'(want_half * CLK_PERIOD_NS));
    end
  endtask

  task automatic run_scenario(input int n);
    @(posedge clk);
    #1;
    load_config(n);
    expected_outcome(cfg_v2, cfg_hc, cfg_busy, cfg_silent);
    restart = 1'b1;
    @(posedge clk);
    #1;
    restart = 1'b0;
    wait (!rst_n);
    wait (rst_n);
    wait (init_done || init_error);
    repeat (4) @(posedge clk);
    ended_cnt = ended_cnt + 1;
    wait (checked_cnt == ended_cnt);
  endtask

  // scenario sequencing
  initial begin
    restart   = 1'b0;
    ended_cnt = 0;
    budget_ns = 0;
    seed      = 30;
    rand_busy = $unsigned($random(seed)) % 6;
    for (int n = 0; n < SCENARIOS; n++) begin
      load_config(n);
      expected_outcome(cfg_v2, cfg_hc, cfg_busy, cfg_silent);
      budget_ns = budget_ns + exp_cmds.size();
    end
    // worst case 150 slow bit times per command, with margin
    budget_ns = 5 * budget_ns * 150 * 2 * SLOW_HALF_PERIOD * CLK_PERIOD_NS;
    wait (rst_n);
    for (int n = 0; n < SCENARIOS; n++) begin
      run_scenario(n);
    end
    $display("** PASS **");
    $finish;
  end

  // checks each finished scenario
  initial begin
    checked_cnt = 0;
    forever begin
      wait (ended_cnt > checked_cnt);
      compare_results();
      checked_cnt = checked_cnt + 1;
    end
  end

  initial begin
    #1;
    #(budget_ns);
    $display("Watchdog: card init never finished within %0d ns", budget_ns);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  input  logic restart,
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD_NS = 2;

  // free running 4 ns clock
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD_NS clk = ~clk;
  end

  // reset low for 10 cycles at start, again on every restart request
  initial begin
    rst_n = 1'b0;
    forever begin
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge restart);
      @(posedge clk);
      #1;
      rst_n = 1'b0;
    end
  end

endmodule
